//--- Makefile
VERILATOR := verilator
FLAGS := --binary --timing --timescale 1ns/1ns
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ns -Wall
TOP := log2_tb
FILE_LIST := files.f
BUILD_DIR := obj_dir
PASS_MESSAGE := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MESSAGE)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/log2_ref.svh
`ifndef LOG2_REF_SVH
`define LOG2_REF_SVH

////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

////////////////////////////////////////////////////////////
// Expected Log2 result
////////////////////////////////////////////////////////////

function automatic void log2_ref(input word32 x_in, output word16 exp_out,
	output word16 frac_out);
	int norm;
	int index;
	int weight;
	word32 value;
	longint table_diff;
	longint acc;
	exp_out = '0;
	frac_out = '0;
	if (x_in > 0) begin
		norm = 0;
		value = x_in;
		// Normalize so the leading one sits in bit 30
		while (value[30] == 1'b0) begin
			value = value << 1;
			norm++;
		end
		exp_out = word16'(30 - norm);
		// Bits 30..25 give 32..63, bits 24..10 the weight
		index = int'(value >>> 25) - 32;
		weight = int'((value >>> 10) & 32'h7fff);
		table_diff = longint'(TABLOG[index]) - longint'(TABLOG[index + 1]);
		acc = (longint'(TABLOG[index]) <<< 16) - ((table_diff * longint'(weight)) <<< 1);
		if (acc > 64'sh7fff_ffff) begin
			acc = 64'sh7fff_ffff;
		end else if (acc < -64'sh8000_0000) begin
			acc = -64'sh8000_0000;
		end
		frac_out = word16'(acc >>> 16);
	end
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input word16 got, input word16 expected);
	if (got !== expected) begin
		$display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
		value_errors++;
	end
endtask

task automatic check_latency(input string name, input int got, input int expected);
	if (got != expected) begin
		$display("[FAIL] %s: got %h cycles, expected %h", name, got, expected);
		timing_errors++;
	end
endtask

`endif

//--- bench/log2_tb.sv
`timescale 1ns/1ns
`default_nettype none

module log2_tb
	import g729_pkg::*;
;

	localparam logic [31:0] LFSR_SEED = 32'hd9e4ee38;
	localparam int NEGATIVE_COUNT = 6;
	localparam word32 NON_POSITIVE [NEGATIVE_COUNT] = '{
		32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
		32'hc000_0000, 32'h8000_0001, 32'hfffe_7960
	};
	localparam int RANDOM_COUNT = 2000;
	localparam int BUSY_COUNT = 4;
	localparam int TEST_COUNT = 31 + 2 * NEGATIVE_COUNT + RANDOM_COUNT + BUSY_COUNT;
	localparam int WATCHDOG_CYCLES = TEST_COUNT * 150;
	localparam int DONE_TIMEOUT = 200;

	logic  clock;
	logic  reset;
	logic  start;
	word32 x;
	logic  done;
	word16 exponent;
	word16 fraction;

	int value_errors = 0;
	int timing_errors = 0;
	int other_errors = 0;
	logic [31:0] lfsr_state = LFSR_SEED;

	// Results still owed by the DUT in order of the starts
	word16 expected_exponent [$];
	word16 expected_fraction [$];
	word16 held_exponent = '0;
	word16 held_fraction = '0;
	word16 want_exponent;
	word16 want_fraction;

	`include "log2_ref.svh"

	log2_top i_dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.x(x),
		.done(done),
		.exponent(exponent),
		.fraction(fraction)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Start one operation and wait for its done pulse
	// A poke is a second start while the DUT is busy
	task automatic run_one(input word32 value, input word16 exp_want, input word16 frac_want,
		input int latency_want, input logic poke_busy);
		int cycles;
		logic seen;
		expected_exponent.push_back(exp_want);
		expected_fraction.push_back(frac_want);
		@(posedge clock);
		start <= 1'b1;
		x <= value;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < DONE_TIMEOUT) begin
			@(posedge clock);
			cycles++;
			start <= poke_busy && (cycles == 4);
			// DUT holds its own copy of x from here on
			x <= ~value;
			@(negedge clock);
			seen = done;
		end
		if (!seen) begin
			$display("No done pulse within %0d cycles of the start for x = %h",
				DONE_TIMEOUT, value);
			other_errors++;
		end else if (latency_want >= 0) begin
			check_latency("done latency", cycles, latency_want);
		end
		if (poke_busy) begin
			// Room for a spurious done to show up
			repeat (100) @(posedge clock);
		end
	endtask

	initial begin
		word32 value;
		word16 exp_want;
		word16 frac_want;
		int shift;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		x = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		// Quiet stretch with outputs held at zero
		repeat (10) @(posedge clock);

		for (int k = 0; k <= 30; k++) begin
			run_one(word32'(1) << k, word16'(k), '0, -1, 1'b0);
		end

		// Non-positive inputs each follow a nonzero result
		log2_ref(32'h7fff_ffff, exp_want, frac_want);
		for (int n = 0; n < NEGATIVE_COUNT; n++) begin
			run_one(32'h7fff_ffff, exp_want, frac_want, -1, 1'b0);
			run_one(NON_POSITIVE[n], '0, '0, 2, 1'b0);
		end

		for (int n = 0; n < RANDOM_COUNT; n++) begin
			shift = int'(take_bits(5)) % 31;
			value = word32'(take_bits(31) >> shift);
			if (value == 0) begin
				value = 1;
			end
			log2_ref(value, exp_want, frac_want);
			run_one(value, exp_want, frac_want, -1, 1'b0);
		end

		// Starts while busy must be ignored
		log2_ref(32'h0000_0001, exp_want, frac_want);
		run_one(32'h0000_0001, exp_want, frac_want, -1, 1'b1);
		log2_ref(32'h0001_2345, exp_want, frac_want);
		run_one(32'h0001_2345, exp_want, frac_want, -1, 1'b1);
		log2_ref(32'h4000_0000, exp_want, frac_want);
		run_one(32'h4000_0000, exp_want, frac_want, -1, 1'b1);
		log2_ref(32'h0abc_def1, exp_want, frac_want);
		run_one(32'h0abc_def1, exp_want, frac_want, -1, 1'b1);

		repeat (20) @(posedge clock);
		if (expected_exponent.size() != 0) begin
			$display("%0d results never arrived", expected_exponent.size());
			other_errors++;
		end
		$display("Errors: %0d value, %0d timing, %0d other",
			value_errors, timing_errors, other_errors);
		if (value_errors + timing_errors + other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset) begin
			if (done) begin
				if (expected_exponent.size() == 0) begin
					$display("Done pulsed at %0t with no start waiting for it", $time);
					other_errors++;
				end else begin
					want_exponent = expected_exponent.pop_front();
					want_fraction = expected_fraction.pop_front();
					check_word("exponent", exponent, want_exponent);
					check_word("fraction", fraction, want_fraction);
					held_exponent = exponent;
					held_fraction = fraction;
				end
			end else begin
				// Outputs only move on done
				check_word("exponent", exponent, held_exponent);
				check_word("fraction", fraction, held_fraction);
			end
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired, the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+bench
source/g729_pkg.sv
source/norm_l.sv
source/l_shl.sv
source/basic_op_unit.sv
source/constant_rom.sv
source/log2_unit.sv
source/log2_top.sv
bench/log2_tb.sv

//--- source/basic_op_unit.sv
`timescale 1ns/1ns
`default_nettype none

module basic_op_unit
	import g729_pkg::*;
(
	input  word16 add_a,
	input  word16 add_b,
	input  word16 sub_a,
	input  word16 sub_b,
	input  word32 shr_value,
	input  word16 shr_count,
	input  word32 msu_acc,
	input  word16 msu_a,
	input  word16 msu_b,
	output word16 add_result,
	output word16 sub_result,
	output word32 shr_result,
	output word32 msu_result
);

	////////////////////////////////////////////////////////////
	// add and sub, one guard bit each
	////////////////////////////////////////////////////////////

	logic signed [16:0] add_sum;
	logic signed [16:0] sub_diff;
	logic add_overflow;
	logic sub_overflow;

	assign add_sum = {add_a[15], add_a} + {add_b[15], add_b};
	assign add_overflow = add_sum[16] != add_sum[15];
	assign add_result = add_overflow ? (add_sum[16] ? MIN_16 : MAX_16) : add_sum[15:0];

	assign sub_diff = {sub_a[15], sub_a} - {sub_b[15], sub_b};
	assign sub_overflow = sub_diff[16] != sub_diff[15];
	assign sub_result = sub_overflow ? (sub_diff[16] ? MIN_16 : MAX_16) : sub_diff[15:0];

	////////////////////////////////////////////////////////////
	// L_shr
	////////////////////////////////////////////////////////////

	always_comb begin
		if (shr_count >= 16'sd31) begin
			// Only sign bits left
			shr_result = shr_value >>> 5'd31;
		end else if (shr_count <= 16'sd0) begin
			// Sequencer only asks for right shifts
			shr_result = shr_value;
		end else begin
			shr_result = shr_value >>> shr_count[4:0];
		end
	end

	////////////////////////////////////////////////////////////
	// L_msu = L_sub(acc, L_mult(a, b))
	////////////////////////////////////////////////////////////

	word32 raw_product;
	word32 msu_product;
	logic  product_overflow;
	logic signed [32:0] msu_diff;
	logic  msu_overflow;

	assign raw_product = word32'(msu_a) * word32'(msu_b);

	// Only -32768 * -32768 overflows when doubled
	assign product_overflow = raw_product == 32'sh4000_0000;
	assign msu_product = product_overflow ? MAX_32 : raw_product <<< 1;

	assign msu_diff = {msu_acc[31], msu_acc} - {msu_product[31], msu_product};
	assign msu_overflow = msu_diff[32] != msu_diff[31];
	assign msu_result = msu_overflow ? (msu_diff[32] ? MIN_32 : MAX_32) : msu_diff[31:0];

endmodule

`default_nettype wire

//--- source/constant_rom.sv
`timescale 1ns/1ns
`default_nettype none

module constant_rom
	import g729_pkg::*;
(
	input  logic    clock,
	input  rom_addr read_addr,
	output word32   data
);

	logic [5:0] region;
	logic [5:0] table_index;
	logic       in_tablog;

	assign region = read_addr[11:6];
	assign table_index = read_addr[5:0];

	// Region decode, then keep the index inside the 33 entries
	assign in_tablog = (region == TABLOG_BASE[11:6]) && (table_index < TABLOG_SIZE);

	////////////////////////////////////////////////////////////
	// Registered read, one cycle of latency
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (in_tablog) begin
			data <= word32'(TABLOG[table_index]);
		end else begin
			data <= '0;
		end
	end

endmodule

`default_nettype wire

//--- source/g729_pkg.sv
`default_nettype none

package g729_pkg;

	////////////////////////////////////////////////////////////
	// Codec word types
	////////////////////////////////////////////////////////////

	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	// Upper six bits pick the table region, lower six index into it
	typedef logic [11:0] rom_addr;

	// Saturation limits of the basic operations
	localparam word16 MAX_16 = 16'sh7fff;
	localparam word16 MIN_16 = 16'sh8000;
	localparam word32 MAX_32 = 32'sh7fff_ffff;
	localparam word32 MIN_32 = 32'sh8000_0000;

	////////////////////////////////////////////////////////////
	// Log2 table
	////////////////////////////////////////////////////////////

	localparam rom_addr TABLOG_BASE = 12'h040;
	localparam int TABLOG_SIZE = 33;

	// log2(1 + i/32) in Q15, the last entry clipped to 32767
	localparam word16 TABLOG [TABLOG_SIZE] = '{
		16'sd0,     16'sd1455,  16'sd2866,  16'sd4236,
		16'sd5568,  16'sd6863,  16'sd8124,  16'sd9352,
		16'sd10549, 16'sd11716, 16'sd12855, 16'sd13967,
		16'sd15054, 16'sd16117, 16'sd17156, 16'sd18172,
		16'sd19167, 16'sd20142, 16'sd21097, 16'sd22033,
		16'sd22951, 16'sd23852, 16'sd24735, 16'sd25603,
		16'sd26455, 16'sd27291, 16'sd28113, 16'sd28922,
		16'sd29716, 16'sd30497, 16'sd31266, 16'sd32023,
		16'sd32767
	};

endpackage

`default_nettype wire

//--- source/l_shl.sv
`timescale 1ns/1ns
`default_nettype none

module l_shl
	import g729_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  start,
	input  word32 value,
	input  word16 count,
	output word32 result,
	output logic  done
);

	logic  busy;
	logic  pending;
	logic  overflow;
	word32 work;
	word16 remaining;

	assign pending = remaining > 16'sd0;

	// Next shift would push out a bit unlike the sign
	assign overflow = pending && (work[31] != work[30]);

	assign done = busy && !pending;
	assign result = work;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			work <= value;
			remaining <= count;
		end else if (busy && pending) begin
			if (overflow) begin
				// Saturate and stop early
				work <= work[31] ? MIN_32 : MAX_32;
				remaining <= '0;
			end else begin
				work <= work << 1;
				remaining <= remaining - 16'sd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/log2_top.sv
`timescale 1ns/1ns
`default_nettype none

module log2_top
	import g729_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  start,
	input  word32 x,
	output logic  done,
	output word16 exponent,
	output word16 fraction
);

	logic    norm_start;
	word32   norm_value;
	word16   norm_count;
	logic    norm_done;
	logic    shl_start;
	word32   shl_value;
	word16   shl_count;
	word32   shl_result;
	logic    shl_done;
	word16   add_a;
	word16   add_b;
	word16   add_result;
	word16   sub_a;
	word16   sub_b;
	word16   sub_result;
	word32   shr_value;
	word16   shr_count;
	word32   shr_result;
	word32   msu_acc;
	word16   msu_a;
	word16   msu_b;
	word32   msu_result;
	rom_addr rom_read_addr;
	word32   rom_data;

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	log2_unit i_log2_unit (
		.clock(clock),
		.reset(reset),
		.start(start),
		.x(x),
		.norm_count(norm_count),
		.norm_done(norm_done),
		.shl_result(shl_result),
		.shl_done(shl_done),
		.add_result(add_result),
		.sub_result(sub_result),
		.shr_result(shr_result),
		.msu_result(msu_result),
		.rom_data(rom_data),
		.done(done),
		.exponent(exponent),
		.fraction(fraction),
		.norm_start(norm_start),
		.norm_value(norm_value),
		.shl_start(shl_start),
		.shl_value(shl_value),
		.shl_count(shl_count),
		.add_a(add_a),
		.add_b(add_b),
		.sub_a(sub_a),
		.sub_b(sub_b),
		.shr_value(shr_value),
		.shr_count(shr_count),
		.msu_acc(msu_acc),
		.msu_a(msu_a),
		.msu_b(msu_b),
		.rom_read_addr(rom_read_addr)
	);

	////////////////////////////////////////////////////////////
	// Shared operators and table
	////////////////////////////////////////////////////////////

	norm_l i_norm_l (
		.clock(clock),
		.reset(reset),
		.start(norm_start),
		.value(norm_value),
		.count(norm_count),
		.done(norm_done)
	);

	l_shl i_l_shl (
		.clock(clock),
		.reset(reset),
		.start(shl_start),
		.value(shl_value),
		.count(shl_count),
		.result(shl_result),
		.done(shl_done)
	);

	basic_op_unit i_basic_op_unit (
		.add_a(add_a),
		.add_b(add_b),
		.sub_a(sub_a),
		.sub_b(sub_b),
		.shr_value(shr_value),
		.shr_count(shr_count),
		.msu_acc(msu_acc),
		.msu_a(msu_a),
		.msu_b(msu_b),
		.add_result(add_result),
		.sub_result(sub_result),
		.shr_result(shr_result),
		.msu_result(msu_result)
	);

	constant_rom i_constant_rom (
		.clock(clock),
		.read_addr(rom_read_addr),
		.data(rom_data)
	);

endmodule

`default_nettype wire

//--- source/log2_unit.sv
`timescale 1ns/1ns
`default_nettype none

module log2_unit
	import g729_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    start,
	input  word32   x,
	input  word16   norm_count,
	input  logic    norm_done,
	input  word32   shl_result,
	input  logic    shl_done,
	input  word16   add_result,
	input  word16   sub_result,
	input  word32   shr_result,
	input  word32   msu_result,
	input  word32   rom_data,
	output logic    done,
	output word16   exponent,
	output word16   fraction,
	output logic    norm_start,
	output word32   norm_value,
	output logic    shl_start,
	output word32   shl_value,
	output word16   shl_count,
	output word16   add_a,
	output word16   add_b,
	output word16   sub_a,
	output word16   sub_b,
	output word32   shr_value,
	output word16   shr_count,
	output word32   msu_acc,
	output word16   msu_a,
	output word16   msu_b,
	output rom_addr rom_read_addr
);

	typedef enum logic [2:0] {
		idle,
		check,
		normalize,
		shift,
		split,
		table_low,
		interpolate,
		finish
	} log2_state;

	log2_state state;

	word32 x_reg;
	word16 norm_shift;
	word16 exp_value;
	word32 shifted;
	word16 table_index;
	word16 weight;
	word16 low_entry;
	logic  non_positive;

	assign non_positive = x_reg[31] || (x_reg == '0);

	////////////////////////////////////////////////////////////
	// State and results
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			done <= 1'b0;
			exponent <= '0;
			fraction <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				idle: begin
					if (start) begin
						state <= check;
					end
				end
				check: begin
					if (non_positive) begin
						exponent <= '0;
						fraction <= '0;
						done <= 1'b1;
						state <= finish;
					end else begin
						state <= normalize;
					end
				end
				normalize: begin
					if (norm_done) begin
						state <= shift;
					end
				end
				shift: begin
					if (shl_done) begin
						state <= split;
					end
				end
				split: state <= table_low;
				table_low: state <= interpolate;
				interpolate: begin
					exponent <= exp_value;
					fraction <= msu_result[31:16];
					done <= 1'b1;
					state <= finish;
				end
				finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Working values of the algorithm
	always_ff @(posedge clock) begin
		case (state)
			idle: begin
				if (start) begin
					x_reg <= x;
				end
			end
			normalize: begin
				if (norm_done) begin
					norm_shift <= norm_count;
				end
			end
			shift: begin
				if (shl_done) begin
					// exponent = 30 - exp, L_x >> 9
					exp_value <= sub_result;
					shifted <= shr_result;
				end
			end
			split: begin
				weight <= shr_result[15:0] & 16'h7fff;
				table_index <= sub_result;
			end
			table_low: low_entry <= rom_data[15:0];
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Operator operands
	////////////////////////////////////////////////////////////

	always_comb begin
		norm_start = 1'b0;
		norm_value = '0;
		shl_start = 1'b0;
		shl_value = '0;
		shl_count = '0;
		add_a = '0;
		add_b = '0;
		sub_a = '0;
		sub_b = '0;
		shr_value = '0;
		shr_count = '0;
		msu_acc = '0;
		msu_b = '0;
		case (state)
			check: begin
				if (!non_positive) begin
					norm_start = 1'b1;
					norm_value = x_reg;
				end
			end
			normalize: begin
				shl_start = norm_done;
				shl_value = x_reg;
				shl_count = norm_count;
			end
			shift: begin
				sub_a = 16'sd30;
				sub_b = norm_shift;
				shr_value = shl_result;
				shr_count = 16'sd9;
			end
			split: begin
				// i = extract_h(L_x) - 32, a from L_x >> 1
				shr_value = shifted;
				shr_count = 16'sd1;
				sub_a = shifted[31:16];
				sub_b = 16'sd32;
			end
			table_low: begin
				add_a = table_index;
				add_b = 16'sd1;
			end
			interpolate: begin
				// tablog[i] - tablog[i+1]
				sub_a = low_entry;
				sub_b = rom_data[15:0];
				msu_acc = {low_entry, 16'h0000};
				msu_b = weight;
			end
			default: ;
		endcase
	end

	// Ports fed back from operator results the same cycle
	always_comb begin
		msu_a = '0;
		rom_read_addr = '0;
		case (state)
			split: rom_read_addr = {TABLOG_BASE[11:6], sub_result[5:0]};
			table_low: rom_read_addr = {TABLOG_BASE[11:6], add_result[5:0]};
			interpolate: msu_a = sub_result;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/norm_l.sv
`timescale 1ns/1ns
`default_nettype none

module norm_l
	import g729_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  start,
	input  word32 value,
	output word16 count,
	output logic  done
);

	logic  busy;
	logic  normalized;
	word32 work;

	// Top two bits differ, or nothing left to normalize
	assign normalized = (work[31] != work[30]) || (work == '0);

	// Done straight from the registers so a count of n costs n+1 cycles
	assign done = busy && normalized;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			count <= '0;
		end else if (busy) begin
			if (normalized) begin
				busy <= 1'b0;
			end else begin
				count <= count + 16'sd1;
			end
		end
	end

	// Working copy, one bit per cycle
	always_ff @(posedge clock) begin
		if (start) begin
			work <= value;
		end else if (busy && !normalized) begin
			work <= work << 1;
		end
	end

endmodule

`default_nettype wire
